//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_plic
RTL_TOP   ?= plic_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		src/plic_pkg.sv src/plic_gateway.sv src/plic_target.sv \
		src/plic_regs.sv src/plic_top.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- src/plic_gateway.sv
`default_nettype none

module plic_gateway
  import plic_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [plic_source_count-1:0] irq_src_i,
  input  logic                         claim_i,
  input  plic_id_t                     claim_id_i,
  input  logic                         complete_i,
  input  plic_id_t                     complete_id_i,
  output logic [plic_source_count-1:0] pending_o
);

  logic [plic_source_count-1:0] pending_q;
  logic [plic_source_count-1:0] pending_d;
  logic [plic_source_count-1:0] in_service_q;
  logic [plic_source_count-1:0] in_service_d;
  logic [plic_source_count-1:0] claim_hit;
  logic [plic_source_count-1:0] complete_hit;

  always_comb begin
    pending_d    = pending_q;
    in_service_d = in_service_q;
    claim_hit    = '0;
    complete_hit = '0;
    for (int s = 0; s < plic_source_count; s++) begin
      claim_hit[s]    = claim_i && (claim_id_i == plic_id_t'(s + 1));
      complete_hit[s] = complete_i && (complete_id_i == plic_id_t'(s + 1));

      // A level line is held off while its source waits or is serviced.
      if (irq_src_i[s] && !pending_q[s] && !in_service_q[s]) begin
        pending_d[s] = 1'b1;
      end
      if (claim_hit[s] && pending_q[s]) begin
        pending_d[s]    = 1'b0;
        in_service_d[s] = 1'b1;
      end
      if (complete_hit[s]) begin
        in_service_d[s] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
    end
  end

  assign pending_o = pending_q;

  a_pending_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pending_q & in_service_q) == '0
  );

  // Targets only report pending sources, so a claim must hit one.
  a_claim_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    claim_i |-> |(claim_hit & pending_q)
  );

endmodule

`default_nettype wire

//--- src/plic_pkg.sv
`default_nettype none

package plic_pkg;

  // Sources are numbered 1 to plic_source_count, id 0 means no interrupt.
  localparam int plic_source_count = 8;
  localparam int plic_source_width = 4;
  localparam int plic_prio_width   = 3;
  localparam int plic_target_count = 2;

  localparam int plic_addr_width = 8;
  localparam int plic_data_width = 32;

  // Word address map of the register port.
  // Priority of source s at base plus s.
  localparam logic [plic_addr_width-1:0] plic_addr_prio_base = 8'h00;

  // Enable mask of target t at base plus t, bit s-1 enables source s.
  localparam logic [plic_addr_width-1:0] plic_addr_ie_base = 8'h10;

  // Threshold of target t at base plus t.
  localparam logic [plic_addr_width-1:0] plic_addr_th_base = 8'h20;

  // Claim on read and complete on write, target t at base plus t.
  localparam logic [plic_addr_width-1:0] plic_addr_claim_base = 8'h30;

  typedef logic [plic_prio_width-1:0] plic_prio_t;

  typedef logic [plic_source_width-1:0] plic_id_t;

  // One register access, req is a single-cycle strobe.
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [plic_addr_width-1:0] addr;
    logic [plic_data_width-1:0] wdata;
  } plic_bus_req_t;

endpackage

`default_nettype wire

//--- src/plic_regs.sv
`default_nettype none

module plic_regs
  import plic_pkg::*;
(
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  plic_bus_req_t                                      bus_i,
  output logic       [plic_data_width-1:0]                   rdata_o,
  input  plic_id_t   [plic_target_count-1:0]                 irq_id_i,
  output plic_prio_t [plic_source_count-1:0]                 prio_o,
  output logic       [plic_target_count-1:0][plic_source_count-1:0] ie_o,
  output plic_prio_t [plic_target_count-1:0]                 threshold_o,
  output logic                                               claim_o,
  output plic_id_t                                           claim_id_o,
  output logic                                               complete_o,
  output plic_id_t                                           complete_id_o
);

  plic_prio_t [plic_source_count-1:0]                 prio_q;
  logic       [plic_target_count-1:0][plic_source_count-1:0] ie_q;
  plic_prio_t [plic_target_count-1:0]                 th_q;
  logic       [plic_data_width-1:0]                   rdata_q;
  logic       [plic_data_width-1:0]                   rdata_d;

  logic [plic_source_count-1:0] prio_sel;
  logic [plic_target_count-1:0] ie_sel;
  logic [plic_target_count-1:0] th_sel;
  logic [plic_target_count-1:0] claim_sel;

  logic rd_en;
  logic wr_en;
  logic wdata_id_ok;

  assign rd_en = bus_i.req && !bus_i.we;
  assign wr_en = bus_i.req && bus_i.we;

  // Only ids 1 to plic_source_count complete a source.
  assign wdata_id_ok = (bus_i.wdata != '0) &&
                       (bus_i.wdata <= plic_data_width'(plic_source_count));

  // One-hot address decode.
  always_comb begin
    prio_sel  = '0;
    ie_sel    = '0;
    th_sel    = '0;
    claim_sel = '0;
    for (int s = 0; s < plic_source_count; s++) begin
      prio_sel[s] = bus_i.addr == plic_addr_prio_base + plic_addr_width'(s + 1);
    end
    for (int t = 0; t < plic_target_count; t++) begin
      ie_sel[t]    = bus_i.addr == plic_addr_ie_base + plic_addr_width'(t);
      th_sel[t]    = bus_i.addr == plic_addr_th_base + plic_addr_width'(t);
      claim_sel[t] = bus_i.addr == plic_addr_claim_base + plic_addr_width'(t);
    end
  end

  // Read mux, unmapped words read 0.
  always_comb begin
    rdata_d = '0;
    for (int s = 0; s < plic_source_count; s++) begin
      if (prio_sel[s]) begin
        rdata_d = plic_data_width'(prio_q[s]);
      end
    end
    for (int t = 0; t < plic_target_count; t++) begin
      if (ie_sel[t]) begin
        rdata_d = plic_data_width'(ie_q[t]);
      end
      if (th_sel[t]) begin
        rdata_d = plic_data_width'(th_q[t]);
      end
      if (claim_sel[t]) begin
        rdata_d = plic_data_width'(irq_id_i[t]);
      end
    end
  end

  // Claim pulses in the strobe cycle with the id being returned.
  always_comb begin
    claim_o       = 1'b0;
    claim_id_o    = '0;
    complete_o    = 1'b0;
    complete_id_o = '0;
    for (int t = 0; t < plic_target_count; t++) begin
      if (claim_sel[t] && rd_en && irq_id_i[t] != '0) begin
        claim_o    = 1'b1;
        claim_id_o = irq_id_i[t];
      end
      if (claim_sel[t] && wr_en && wdata_id_ok) begin
        complete_o    = 1'b1;
        complete_id_o = bus_i.wdata[plic_source_width-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_q <= '0;
      ie_q   <= '0;
      th_q   <= '0;
    end else if (wr_en) begin
      for (int s = 0; s < plic_source_count; s++) begin
        if (prio_sel[s]) begin
          prio_q[s] <= bus_i.wdata[plic_prio_width-1:0];
        end
      end
      for (int t = 0; t < plic_target_count; t++) begin
        if (ie_sel[t]) begin
          ie_q[t] <= bus_i.wdata[plic_source_count-1:0];
        end
        if (th_sel[t]) begin
          th_q[t] <= bus_i.wdata[plic_prio_width-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o     = rdata_q;
  assign prio_o      = prio_q;
  assign ie_o        = ie_q;
  assign threshold_o = th_q;

  a_claim_complete_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(claim_o && complete_o)
  );

endmodule

`default_nettype wire

//--- src/plic_target.sv
`default_nettype none

module plic_target
  import plic_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic       [plic_source_count-1:0]       pending_i,
  input  logic       [plic_source_count-1:0]       ie_i,
  input  plic_prio_t [plic_source_count-1:0]       prio_i,
  input  plic_prio_t                               threshold_i,
  output logic                                     irq_req_o,
  output plic_id_t                                 irq_id_o
);

  plic_prio_t max_prio;
  logic       irq_req_d;
  plic_id_t   irq_id_d;
  logic       irq_req_q;
  plic_id_t   irq_id_q;

  // High to low scan, an equal priority further down replaces the winner.
  always_comb begin
    max_prio  = threshold_i;
    irq_req_d = 1'b0;
    irq_id_d  = '0;
    for (int s = plic_source_count - 1; s >= 0; s--) begin
      if (pending_i[s] && ie_i[s] && prio_i[s] > threshold_i && prio_i[s] >= max_prio) begin
        max_prio  = prio_i[s];
        irq_req_d = 1'b1;
        irq_id_d  = plic_id_t'(s + 1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_req_q <= 1'b0;
      irq_id_q  <= '0;
    end else begin
      irq_req_q <= irq_req_d;
      irq_id_q  <= irq_id_d;
    end
  end

  assign irq_req_o = irq_req_q;
  assign irq_id_o  = irq_id_q;

  a_req_id: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_req_o == (irq_id_o != '0)
  );

endmodule

`default_nettype wire

//--- src/plic_top.sv
`default_nettype none

module plic_top
  import plic_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [plic_source_count-1:0] irq_src_i,
  input  plic_bus_req_t                bus_i,
  output logic [plic_data_width-1:0]   rdata_o,
  output logic [plic_target_count-1:0] irq_o
);

  logic       [plic_source_count-1:0]                         pending;
  plic_prio_t [plic_source_count-1:0]                         prio;
  logic       [plic_target_count-1:0][plic_source_count-1:0]  ie;
  plic_prio_t [plic_target_count-1:0]                         threshold;
  plic_id_t   [plic_target_count-1:0]                         irq_id;

  logic     claim;
  plic_id_t claim_id;
  logic     complete;
  plic_id_t complete_id;

  plic_gateway u_gateway (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_src_i     (irq_src_i),
    .claim_i       (claim),
    .claim_id_i    (claim_id),
    .complete_i    (complete),
    .complete_id_i (complete_id),
    .pending_o     (pending)
  );

  plic_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus_i         (bus_i),
    .rdata_o       (rdata_o),
    .irq_id_i      (irq_id),
    .prio_o        (prio),
    .ie_o          (ie),
    .threshold_o   (threshold),
    .claim_o       (claim),
    .claim_id_o    (claim_id),
    .complete_o    (complete),
    .complete_id_o (complete_id)
  );

  // Pending state is shared, each target has its own mask and threshold.
  for (genvar t = 0; t < plic_target_count; t++) begin : g_target
    plic_target u_target (
      .clk         (clk),
      .rst_n       (rst_n),
      .pending_i   (pending),
      .ie_i        (ie[t]),
      .prio_i      (prio),
      .threshold_i (threshold[t]),
      .irq_req_o   (irq_o[t]),
      .irq_id_o    (irq_id[t])
    );
  end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
  end

  // 10 ns period.
  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb/tb_plic.sv
`default_nettype none

module tb_plic
  import plic_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_cycles = 4000;

  logic                         clk;
  logic                         rst_n;
  logic [plic_source_count-1:0] irq_src;
  plic_bus_req_t                bus;
  logic [plic_data_width-1:0]   rdata;
  logic [plic_target_count-1:0] irq;

  // Reference copies of the configuration and gateway state.
  logic [2:0] prio_m [1:8];
  logic [7:0] ie_m [0:1];
  logic [2:0] th_m [0:1];
  logic [8:1] pend_m;
  logic [8:1] serv_m;

  logic [15:0] lfsr_q;
  int          checks;
  int          errors;
  int          cycles;

  tb_clock u_clock (
    .clk_o (clk)
  );

  plic_top u_plic_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq_src_i (irq_src),
    .bus_i     (bus),
    .rdata_o   (rdata),
    .irq_o     (irq)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[6:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Only priorities strictly above the threshold count and the ascending scan
  // keeps the lowest id on ties.
  function automatic int expected_id(input int t);
    int       best;
    logic [2:0] top;
    best = 0;
    top  = th_m[t];
    for (int s = 1; s <= 8; s++) begin
      if (pend_m[s] && ie_m[t][s-1] && prio_m[s] > top) begin
        top  = prio_m[s];
        best = s;
      end
    end
    return best;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_n   <= 1'b0;
    irq_src <= '0;
    bus     <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int s = 1; s <= 8; s++) begin
      prio_m[s] = '0;
    end
    for (int t = 0; t < 2; t++) begin
      ie_m[t] = '0;
      th_m[t] = '0;
    end
    pend_m = '0;
    serv_m = '0;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    bus <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    bus <= '0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    bus <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clk);
    bus <= '0;
    @(negedge clk);
    data = rdata;
  endtask

  task automatic set_prio(input int s, input logic [31:0] val);
    bus_write(plic_addr_prio_base + 8'(s), val);
    prio_m[s] = val[2:0];
  endtask

  task automatic set_ie(input int t, input logic [31:0] val);
    bus_write(plic_addr_ie_base + 8'(t), val);
    ie_m[t] = val[7:0];
  endtask

  task automatic set_th(input int t, input logic [31:0] val);
    bus_write(plic_addr_th_base + 8'(t), val);
    th_m[t] = val[2:0];
  endtask

  task automatic set_lines(input logic [7:0] mask);
    @(posedge clk);
    irq_src <= mask;
    for (int s = 1; s <= 8; s++) begin
      if (mask[s-1] && !serv_m[s]) begin
        pend_m[s] = 1'b1;
      end
    end
  endtask

  task automatic claim_check(input string name, input int t, output int id);
    logic [31:0] data;
    int          exp;
    exp = expected_id(t);
    bus_read(plic_addr_claim_base + 8'(t), data);
    check_eq(name, exp, data);
    id = data;
    if (exp != 0) begin
      pend_m[exp] = 1'b0;
      serv_m[exp] = 1'b1;
    end
  endtask

  task automatic complete_id(input int t, input int id);
    bus_write(plic_addr_claim_base + 8'(t), id);
    serv_m[id] = 1'b0;
    if (irq_src[id-1]) begin
      pend_m[id] = 1'b1;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    $display("%s: finished with %0d errors", name, errors - errs_before);
  endtask

  task automatic test_reset_readback();
    int          e0;
    logic [31:0] data;
    e0 = errors;
    reset_dut();
    wait_cycles(1);
    check_eq("reset irq", 0, irq);
    for (int s = 1; s <= 8; s++) begin
      bus_read(plic_addr_prio_base + 8'(s), data);
      check_eq("reset prio", 0, data);
    end
    for (int t = 0; t < 2; t++) begin
      bus_read(plic_addr_ie_base + 8'(t), data);
      check_eq("reset ie", 0, data);
      bus_read(plic_addr_th_base + 8'(t), data);
      check_eq("reset threshold", 0, data);
      bus_read(plic_addr_claim_base + 8'(t), data);
      check_eq("reset claim", 0, data);
    end
    set_prio(3, 32'hffff_fffd);
    bus_read(plic_addr_prio_base + 8'd3, data);
    check_eq("prio width", 32'h5, data);
    set_ie(1, 32'h1234_5678);
    bus_read(plic_addr_ie_base + 8'd1, data);
    check_eq("ie width", 32'h78, data);
    set_th(0, 32'h0000_000f);
    bus_read(plic_addr_th_base + 8'd0, data);
    check_eq("threshold width", 32'h7, data);
    bus_write(8'h40, 32'hdead_beef);
    bus_read(8'h40, data);
    check_eq("unmapped 0x40", 0, data);
    bus_read(8'h09, data);
    check_eq("unmapped 0x09", 0, data);
    report("reset_readback", e0);
  endtask

  task automatic test_arbitration();
    int e0;
    int id;
    e0 = errors;
    reset_dut();
    for (int s = 1; s <= 8; s++) begin
      set_prio(s, rand_bits(3));
    end
    set_ie(0, rand_bits(8));
    set_ie(1, rand_bits(8));
    set_lines(8'had);
    wait_cycles(2);
    claim_check("arbitration target 0", 0, id);
    wait_cycles(2);
    claim_check("arbitration target 1", 1, id);
    wait_cycles(2);
    // Equal priorities on sources 2 and 5.
    reset_dut();
    set_prio(2, 4);
    set_prio(5, 4);
    set_ie(0, 8'hff);
    set_lines(8'h12);
    wait_cycles(2);
    claim_check("tie lower id", 0, id);
    check_eq("tie winner", 2, id);
    report("arbitration", e0);
  endtask

  task automatic test_threshold();
    int e0;
    e0 = errors;
    reset_dut();
    set_prio(1, 3);
    set_ie(0, 8'h01);
    set_th(0, 3);
    set_lines(8'h01);
    wait_cycles(2);
    check_eq("equal threshold", 0, irq[0]);
    set_th(0, 2);
    wait_cycles(1);
    check_eq("lowered threshold", 1, irq[0]);
    report("threshold", e0);
  endtask

  task automatic test_claim_complete();
    int e0;
    int id;
    e0 = errors;
    reset_dut();
    set_prio(4, 2);
    set_ie(0, 8'h08);
    set_lines(8'h08);
    wait_cycles(2);
    check_eq("claim irq before", 1, irq[0]);
    claim_check("claim id", 0, id);
    wait_cycles(1);
    check_eq("irq after claim", 0, irq[0]);
    wait_cycles(3);
    check_eq("held while in service", 0, irq[0]);
    complete_id(0, 4);
    wait_cycles(2);
    check_eq("irq after complete", 1, irq[0]);
    set_lines(8'h00);
    claim_check("second claim", 0, id);
    complete_id(0, id);
    wait_cycles(2);
    claim_check("claim without request", 0, id);
    check_eq("empty claim", 0, id);
    report("claim_complete", e0);
  endtask

  task automatic test_independent();
    int e0;
    int id0;
    int id1;
    e0 = errors;
    reset_dut();
    set_prio(1, 1);
    set_prio(2, 2);
    set_prio(3, 3);
    set_ie(0, 8'h03);
    set_ie(1, 8'h06);
    set_lines(8'h07);
    wait_cycles(2);
    check_eq("both targets request", 2'b11, irq);
    claim_check("target 1 winner", 1, id1);
    wait_cycles(2);
    claim_check("target 0 winner", 0, id0);
    checks++;
    if (id0 == id1) begin
      errors++;
      $display("Both targets returned the same winner %0d", id0);
    end
    wait_cycles(2);
    claim_check("shared pending", 1, id1);
    check_eq("target 1 after shared claim", 0, id1);
    wait_cycles(1);
    check_eq("only target 0 requests", 2'b01, irq);
    report("independent_targets", e0);
  endtask

  initial begin
    rst_n   = 1'b0;
    irq_src = '0;
    bus     = '0;
    lfsr_q  = 16'd45643;
    checks  = 0;
    errors  = 0;
    cycles  = 0;
    test_reset_readback();
    test_arbitration();
    test_threshold();
    test_claim_complete();
    test_independent();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/plic_pkg.sv
src/plic_gateway.sv
src/plic_target.sv
src/plic_regs.sv
src/plic_top.sv
tb/tb_clock.sv
tb/tb_plic.sv
